// ==== Bender.yml ====
package:
  name: slc3

sources:
  - rtl/slc3_isa_pkg.sv
  - rtl/slc3_ctrl_pkg.sv
  - rtl/reg_file.sv
  - rtl/cpu_control.sv
  - rtl/cpu.sv
  - rtl/sync_sram.sv
  - rtl/slc3_top.sv
  - target: test
    files:
      - dv/slc3_tb.sv

// ==== dv/slc3_tb.sv ====
`timescale 1ns/1ns

module slc3_tb;

    import slc3_isa_pkg::*;

    localparam int NUM_TESTS      = 5;
    localparam int MAX_WORDS      = 32;
    localparam int MAX_PAUSES     = 4;
    localparam int MAX_CHECKS     = 10;
    localparam int TIMEOUT_CYCLES = 2000;
    localparam logic [LED_W-1:0] LAST_PAUSE = 12'hFFF;

    logic             clk;
    logic             rst_i;
    logic             run_i;
    logic             continue_i;
    logic             prog_we_i;
    mem_addr_t        prog_addr_i;
    word_t            prog_data_i;
    word_t            prog_rdata_o;
    logic [LED_W-1:0] led_o;
    word_t            hex_o;
    logic             paused_o;

    // Per test: program words, LED value at each PAUSE, memory after the run
    string            test_name [NUM_TESTS];
    mem_addr_t        prog_addr [NUM_TESTS][MAX_WORDS];
    word_t            prog_word [NUM_TESTS][MAX_WORDS];
    int               prog_len  [NUM_TESTS];
    logic [LED_W-1:0] led_exp   [NUM_TESTS][MAX_PAUSES];
    int               led_len   [NUM_TESTS];
    mem_addr_t        chk_addr  [NUM_TESTS][MAX_CHECKS];
    word_t            chk_word  [NUM_TESTS][MAX_CHECKS];
    int               chk_len   [NUM_TESTS];

    int    error_count;
    int    check_count;
    int    tests_failed;
    word_t op_a;
    word_t op_b;

    slc3_top UUT (
        .clk(clk), .rst_i(rst_i), .run_i(run_i), .continue_i(continue_i),
        .prog_we_i(prog_we_i), .prog_addr_i(prog_addr_i), .prog_data_i(prog_data_i),
        .prog_rdata_o(prog_rdata_o), .led_o(led_o), .hex_o(hex_o), .paused_o(paused_o)
    );

    always #50 clk = ~clk;

    // --------------------------------------------------
    // Instruction encoders, straight from the ISA fields
    // --------------------------------------------------
    function automatic word_t add_regs(input reg_idx_t dr, input reg_idx_t sa, input reg_idx_t sb);
        return {OP_ADD, dr, sa, 3'b000, sb};
    endfunction

    function automatic word_t add_imm(input reg_idx_t dr, input reg_idx_t sa, input int imm);
        return {OP_ADD, dr, sa, 1'b1, imm[4:0]};
    endfunction

    function automatic word_t and_regs(input reg_idx_t dr, input reg_idx_t sa, input reg_idx_t sb);
        return {OP_AND, dr, sa, 3'b000, sb};
    endfunction

    function automatic word_t and_imm(input reg_idx_t dr, input reg_idx_t sa, input int imm);
        return {OP_AND, dr, sa, 1'b1, imm[4:0]};
    endfunction

    function automatic word_t not_reg(input reg_idx_t dr, input reg_idx_t sa);
        return {OP_NOT, dr, sa, 6'b111111};
    endfunction

    function automatic word_t branch(input logic [2:0] nzp, input int off);
        return {OP_BR, nzp, off[8:0]};
    endfunction

    function automatic word_t jump_reg(input reg_idx_t base);
        return {OP_JMP, 3'b000, base, 6'b000000};
    endfunction

    function automatic word_t jsr_rel(input int off);
        return {OP_JSR, 1'b1, off[10:0]};
    endfunction

    function automatic word_t load_rel(input reg_idx_t dr, input reg_idx_t base, input int off);
        return {OP_LDR, dr, base, off[5:0]};
    endfunction

    function automatic word_t store_rel(input reg_idx_t sr, input reg_idx_t base, input int off);
        return {OP_STR, sr, base, off[5:0]};
    endfunction

    function automatic word_t pause_led(input logic [LED_W-1:0] led);
        return {OP_PAUSE, led};
    endfunction

    function automatic word_t fill_word(input mem_addr_t addr);
        return {~addr, addr};
    endfunction

    // --------------------------------------------------
    // Table construction
    // --------------------------------------------------
    task automatic add_word(input int t, input int addr, input word_t w);
        prog_addr[t][prog_len[t]] = mem_addr_t'(addr);
        prog_word[t][prog_len[t]] = w;
        prog_len[t]++;
    endtask

    task automatic add_led(input int t, input logic [LED_W-1:0] led);
        led_exp[t][led_len[t]] = led;
        led_len[t]++;
    endtask

    task automatic add_check(input int t, input int addr, input word_t w);
        chk_addr[t][chk_len[t]] = mem_addr_t'(addr);
        chk_word[t][chk_len[t]] = w;
        chk_len[t]++;
    endtask

    // R6 = 8 doubled three times, the data base 0x40
    task automatic add_base(input int t, input int start);
        add_word(t, start, add_imm(6, 0, 8));
        add_word(t, start + 1, add_regs(6, 6, 6));
        add_word(t, start + 2, add_regs(6, 6, 6));
        add_word(t, start + 3, add_regs(6, 6, 6));
    endtask

    task automatic build_tests();
        for (int t = 0; t < NUM_TESTS; t++) begin
            prog_len[t] = 0;
            led_len[t]  = 0;
            chk_len[t]  = 0;
        end
        test_name[0] = "reset";
        add_word(0, 0, pause_led(LAST_PAUSE));
        add_check(0, 8'h40, fill_word(8'h40));

        test_name[1] = "alu";
        op_a = word_t'($urandom());
        op_b = word_t'($urandom());
        add_base(1, 0);
        add_word(1, 4, load_rel(1, 6, 0));
        add_word(1, 5, load_rel(2, 6, 1));
        add_word(1, 6, add_regs(3, 1, 2));
        add_word(1, 7, store_rel(3, 6, 2));
        add_word(1, 8, and_imm(4, 1, -6));
        add_word(1, 9, store_rel(4, 6, 3));
        add_word(1, 10, not_reg(5, 2));
        add_word(1, 11, store_rel(5, 6, 4));
        add_word(1, 12, add_imm(3, 1, 7));
        add_word(1, 13, store_rel(3, 6, 5));
        add_word(1, 14, and_regs(4, 1, 2));
        add_word(1, 15, store_rel(4, 6, 6));
        add_word(1, 16, add_imm(5, 1, -16));
        add_word(1, 17, store_rel(5, 6, 7));
        add_word(1, 18, pause_led(LAST_PAUSE));
        add_word(1, 8'h40, op_a);
        add_word(1, 8'h41, op_b);
        add_check(1, 8'h40, op_a);
        add_check(1, 8'h41, op_b);
        add_check(1, 8'h42, op_a + op_b);
        add_check(1, 8'h43, op_a & 16'hFFFA);
        add_check(1, 8'h44, ~op_b);
        add_check(1, 8'h45, op_a + 16'd7);
        add_check(1, 8'h46, op_a & op_b);
        add_check(1, 8'h47, op_a - 16'd16);

        // Each skipped STR leaves its word at the fill value
        test_name[2] = "branch";
        add_base(2, 0);
        add_word(2, 4, and_imm(1, 1, 0));
        add_word(2, 5, branch(3'b010, 2));
        add_word(2, 6, add_imm(2, 0, 1));
        add_word(2, 7, store_rel(2, 6, 0));
        add_word(2, 8, add_imm(2, 0, 2));
        add_word(2, 9, store_rel(2, 6, 1));
        add_word(2, 10, branch(3'b100, 2));
        add_word(2, 11, add_imm(2, 0, 3));
        add_word(2, 12, store_rel(2, 6, 2));
        add_word(2, 13, add_imm(2, 0, -4));
        add_word(2, 14, branch(3'b100, 2));
        add_word(2, 15, add_imm(2, 0, 5));
        add_word(2, 16, store_rel(2, 6, 3));
        add_word(2, 17, store_rel(2, 6, 4));
        add_word(2, 18, branch(3'b011, 2));
        add_word(2, 19, add_imm(2, 0, 6));
        add_word(2, 20, store_rel(2, 6, 5));
        add_word(2, 21, branch(3'b001, 2));
        add_word(2, 22, add_imm(2, 0, 7));
        add_word(2, 23, store_rel(2, 6, 6));
        add_word(2, 24, branch(3'b110, 1));
        add_word(2, 25, store_rel(2, 6, 7));
        add_word(2, 26, pause_led(LAST_PAUSE));
        add_check(2, 8'h40, fill_word(8'h40));
        add_check(2, 8'h41, 16'h0002);
        add_check(2, 8'h42, 16'h0003);
        add_check(2, 8'h43, fill_word(8'h43));
        add_check(2, 8'h44, 16'hFFFC);
        add_check(2, 8'h45, 16'h0006);
        add_check(2, 8'h46, fill_word(8'h46));
        add_check(2, 8'h47, 16'h0006);

        // A JSR that lands one word short hits the stray store at 8
        test_name[3] = "jsr_jmp";
        add_base(3, 0);
        add_word(3, 4, jsr_rel(4));
        add_word(3, 5, add_imm(2, 0, 9));
        add_word(3, 6, store_rel(2, 6, 1));
        add_word(3, 7, pause_led(LAST_PAUSE));
        add_word(3, 8, store_rel(6, 6, 2));
        add_word(3, 9, store_rel(7, 6, 0));
        add_word(3, 10, jump_reg(7));
        add_check(3, 8'h40, 16'h0005);
        add_check(3, 8'h41, 16'h0009);
        add_check(3, 8'h42, fill_word(8'h42));

        test_name[4] = "pause";
        add_word(4, 0, pause_led(12'h5A3));
        add_base(4, 1);
        add_word(4, 5, add_imm(2, 0, 11));
        add_word(4, 6, store_rel(2, 6, 0));
        add_word(4, 7, pause_led(LAST_PAUSE));
        add_led(4, 12'h5A3);
        add_check(4, 8'h40, 16'h000B);
    endtask

    // --------------------------------------------------
    // Bus-level helpers
    // --------------------------------------------------
    task automatic step();
        @(posedge clk);
        #10;
    endtask

    task automatic check_value(input string name, input word_t expected, input word_t actual);
        check_count++;
        assert (actual === expected)
        else begin
            $display("** Error at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
            error_count++;
        end
    endtask

    task automatic wait_paused(input logic level, input string what);
        int cycles;
        cycles = 0;
        while (paused_o !== level && cycles < TIMEOUT_CYCLES) begin
            step();
            cycles++;
        end
        if (paused_o !== level) begin
            $display("Timeout at %0t ns after %0d cycles waiting for %s", $time, cycles, what);
            $display("STATUS: FAIL");
            $finish;
        end
    endtask

    task automatic apply_reset();
        rst_i      = 1'b1;
        run_i      = 1'b0;
        continue_i = 1'b0;
        prog_we_i  = 1'b0;
        repeat (16) step();
        rst_i = 1'b0;
        step();
        check_value("paused_o", 16'd1, paused_o);
        check_value("led_o", 16'd0, led_o);
        check_value("hex_o", 16'd0, hex_o);
    endtask

    task automatic write_word(input mem_addr_t addr, input word_t data);
        prog_addr_i = addr;
        prog_data_i = data;
        prog_we_i   = 1'b1;
        step();
        prog_we_i = 1'b0;
    endtask

    task automatic load_program(input int t);
        for (int i = 0; i < MEM_DEPTH; i++) begin
            write_word(mem_addr_t'(i), fill_word(mem_addr_t'(i)));
        end
        for (int i = 0; i < prog_len[t]; i++) begin
            write_word(prog_addr[t][i], prog_word[t][i]);
        end
    endtask

    task automatic pulse_run();
        run_i = 1'b1;
        step();
        run_i = 1'b0;
    endtask

    // FSM must sit still until continue_i is pressed and then released.
    // Held long enough that an early fetch would already have reloaded IR.
    task automatic hold_pause(input logic [LED_W-1:0] shown);
        repeat (4) begin
            step();
            check_value("paused_o", 16'd1, paused_o);
            check_value("hex_o", pause_led(shown), hex_o);
        end
        continue_i = 1'b1;
        wait_paused(1'b0, "continue_i to be accepted");
        repeat (6) begin
            step();
            check_value("paused_o", 16'd0, paused_o);
            check_value("hex_o", pause_led(shown), hex_o);
        end
        continue_i = 1'b0;
        step();
    endtask

    task automatic follow_pauses(input int t);
        int               seen;
        logic             done;
        logic [LED_W-1:0] want;
        seen = 0;
        done = 1'b0;
        while (!done && seen <= MAX_PAUSES) begin
            wait_paused(1'b1, "a PAUSE");
            // LEDs load one cycle into the pause
            step();
            if (hex_o[LED_W-1:0] == LAST_PAUSE) begin
                done = 1'b1;
                check_value("led_o", LAST_PAUSE, led_o);
                check_value("hex_o", pause_led(LAST_PAUSE), hex_o);
                assert (seen == led_len[t])
                else begin
                    $display("Program ended after %0d of %0d pauses", seen, led_len[t]);
                    error_count++;
                end
            end else begin
                want = (seen < led_len[t]) ? led_exp[t][seen] : '0;
                assert (seen < led_len[t])
                else begin
                    $display("Program paused more often than expected at %0t ns", $time);
                    error_count++;
                end
                check_value("led_o", want, led_o);
                check_value("hex_o", pause_led(want), hex_o);
                hold_pause(want);
                seen++;
            end
        end
        assert (done)
        else begin
            $display("Program never reached its final PAUSE");
            error_count++;
        end
    endtask

    task automatic check_memory(input int t);
        prog_we_i = 1'b0;
        for (int i = 0; i < chk_len[t]; i++) begin
            prog_addr_i = chk_addr[t][i];
            step();
            check_value($sformatf("mem[%02h]", chk_addr[t][i]), chk_word[t][i], prog_rdata_o);
        end
    endtask

    task automatic run_test(input int t);
        int errors_before;
        errors_before = error_count;
        apply_reset();
        load_program(t);
        pulse_run();
        follow_pauses(t);
        check_memory(t);
        if (error_count == errors_before) begin
            $display("Test %0d (%s): ok", t, test_name[t]);
        end else begin
            tests_failed++;
            $display("Test %0d (%s): %0d errors", t, test_name[t], error_count - errors_before);
        end
    endtask

    // --------------------------------------------------
    // Main sequence
    // --------------------------------------------------
    initial begin
        clk          = 1'b0;
        rst_i        = 1'b1;
        run_i        = 1'b0;
        continue_i   = 1'b0;
        prog_we_i    = 1'b0;
        prog_addr_i  = '0;
        prog_data_i  = '0;
        error_count  = 0;
        check_count  = 0;
        tests_failed = 0;
        void'($urandom(3098));
        build_tests();
        for (int t = 0; t < NUM_TESTS; t++) begin
            run_test(t);
        end
        $display("Tests run: %0d, failed: %0d, checks: %0d, errors: %0d",
                 NUM_TESTS, tests_failed, check_count, error_count);
        if (error_count == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

// ==== rtl/cpu.sv ====
`timescale 1ns/1ns

module cpu (
    input  logic                           clk,
    input  logic                           rst_i,
    input  logic                           run_i,
    input  logic                           continue_i,
    input  slc3_isa_pkg::word_t            mem_rdata_i,
    output slc3_isa_pkg::word_t            mem_wdata_o,
    output slc3_isa_pkg::word_t            mem_addr_o,
    output logic                           mem_ena_o,
    output logic                           mem_we_o,
    output logic [slc3_isa_pkg::LED_W-1:0] led_o,
    output slc3_isa_pkg::word_t            hex_o,
    output logic                           paused_o
);

    import slc3_isa_pkg::*;
    import slc3_ctrl_pkg::*;

    logic     ld_mar, ld_mdr, ld_ir, ld_pc, ld_reg, ld_cc, ld_ben, ld_led;
    logic     addr1_sel, sr1_sel, sr2_sel, dr_sel, mio_sel;
    bus_sel_e bus_sel;
    aluk_e    aluk;
    pcmux_e   pcmux;
    addr2_e   addr2_sel;

    word_t    pc, ir, mar, mdr, bus;
    word_t    pc_next, mdr_next;
    word_t    sr1_val, sr2_val, alu_b, alu_out;
    word_t    addr1, addr2, marmux;
    word_t    sext5, sext6, sext9, sext11;
    reg_idx_t dr, sr1;
    logic     n, z, p, ben;

    cpu_control u_control (
        .clk(clk), .rst_i(rst_i), .run_i(run_i), .continue_i(continue_i),
        .ir_i(ir), .ben_i(ben),
        .ld_mar_o(ld_mar), .ld_mdr_o(ld_mdr), .ld_ir_o(ld_ir), .ld_pc_o(ld_pc),
        .ld_reg_o(ld_reg), .ld_cc_o(ld_cc), .ld_ben_o(ld_ben), .ld_led_o(ld_led),
        .bus_sel_o(bus_sel), .aluk_o(aluk), .pcmux_o(pcmux), .addr2_sel_o(addr2_sel),
        .addr1_sel_o(addr1_sel), .sr1_sel_o(sr1_sel), .sr2_sel_o(sr2_sel),
        .dr_sel_o(dr_sel), .mio_sel_o(mio_sel),
        .mem_ena_o(mem_ena_o), .mem_we_o(mem_we_o), .paused_o(paused_o)
    );

    reg_file u_reg_file (
        .clk(clk), .rst_i(rst_i), .ld_reg_i(ld_reg),
        .dr_i(dr), .sr1_i(sr1), .sr2_i(ir[2:0]),
        .bus_i(bus), .sr1_o(sr1_val), .sr2_o(sr2_val)
    );

    // --------------------------------------------------
    // Operand muxes and sign extension
    // --------------------------------------------------
    assign dr     = dr_sel  ? 3'd7 : ir[11:9];
    assign sr1    = sr1_sel ? ir[8:6] : ir[11:9];
    assign sext5  = {{11{ir[4]}}, ir[4:0]};
    assign sext6  = {{10{ir[5]}}, ir[5:0]};
    assign sext9  = {{7{ir[8]}}, ir[8:0]};
    assign sext11 = {{5{ir[10]}}, ir[10:0]};
    assign alu_b  = sr2_sel ? sext5 : sr2_val;
    assign addr1  = addr1_sel ? sr1_val : pc;

    always_comb begin
        case (addr2_sel)
            ADDR2_OFF6:  addr2 = sext6;
            ADDR2_OFF9:  addr2 = sext9;
            ADDR2_OFF11: addr2 = sext11;
            default:     addr2 = '0;
        endcase
    end

    assign marmux = addr1 + addr2;

    always_comb begin
        case (aluk)
            ALU_ADD: alu_out = sr1_val + alu_b;
            ALU_AND: alu_out = sr1_val & alu_b;
            ALU_NOT: alu_out = ~sr1_val;
            default: alu_out = sr1_val;
        endcase
    end

    always_comb begin
        case (bus_sel)
            BUS_PC:  bus = pc;
            BUS_MDR: bus = mdr;
            BUS_ALU: bus = alu_out;
            default: bus = marmux;
        endcase
    end

    always_comb begin
        case (pcmux)
            PC_BUS:   pc_next = bus;
            PC_ADDER: pc_next = marmux;
            default:  pc_next = pc + 16'd1;
        endcase
    end

    assign mdr_next = mio_sel ? mem_rdata_i : bus;

    // --------------------------------------------------
    // Registers
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst_i) begin
            pc    <= '0;
            ir    <= '0;
            n     <= 1'b0;
            z     <= 1'b1;
            p     <= 1'b0;
            ben   <= 1'b0;
            led_o <= '0;
        end else begin
            if (ld_pc) pc <= pc_next;
            if (ld_ir) ir <= bus;
            // Codes from the value being written back
            if (ld_cc) begin
                n <= bus[15];
                z <= (bus == '0);
                p <= !bus[15] && (bus != '0);
            end
            if (ld_ben) ben <= (n & ir[11]) | (z & ir[10]) | (p & ir[9]);
            if (ld_led) led_o <= ir[LED_W-1:0];
        end
    end

    always_ff @(posedge clk) begin
        if (ld_mar) mar <= bus;
        if (ld_mdr) mdr <= mdr_next;
    end

    assign mem_addr_o  = mar;
    assign mem_wdata_o = mdr;
    assign hex_o       = ir;

endmodule

// ==== rtl/cpu_control.sv ====
`timescale 1ns/1ns

module cpu_control (
    input  logic                      clk,
    input  logic                      rst_i,
    input  logic                      run_i,
    input  logic                      continue_i,
    input  slc3_isa_pkg::word_t       ir_i,
    input  logic                      ben_i,
    output logic                      ld_mar_o,
    output logic                      ld_mdr_o,
    output logic                      ld_ir_o,
    output logic                      ld_pc_o,
    output logic                      ld_reg_o,
    output logic                      ld_cc_o,
    output logic                      ld_ben_o,
    output logic                      ld_led_o,
    output slc3_ctrl_pkg::bus_sel_e   bus_sel_o,
    output slc3_ctrl_pkg::aluk_e      aluk_o,
    output slc3_ctrl_pkg::pcmux_e     pcmux_o,
    output slc3_ctrl_pkg::addr2_e     addr2_sel_o,
    output logic                      addr1_sel_o,
    output logic                      sr1_sel_o,
    output logic                      sr2_sel_o,
    output logic                      dr_sel_o,
    output logic                      mio_sel_o,
    output logic                      mem_ena_o,
    output logic                      mem_we_o,
    output logic                      paused_o
);

    import slc3_isa_pkg::*;
    import slc3_ctrl_pkg::*;

    state_e state;
    state_e state_next;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            state <= S_HALTED;
        end else begin
            state <= state_next;
        end
    end

    // --------------------------------------------------
    // Next state
    // --------------------------------------------------
    always_comb begin
        state_next = state;
        case (state)
            S_HALTED:     if (run_i) state_next = S_FETCH_MAR;
            S_FETCH_MAR:  state_next = S_FETCH_RD;
            S_FETCH_RD:   state_next = S_FETCH_WAIT;
            S_FETCH_WAIT: state_next = S_FETCH_IR;
            S_FETCH_IR:   state_next = S_DECODE;
            S_DECODE: begin
                case (opcode_e'(ir_i[15:12]))
                    OP_ADD:   state_next = S_ADD;
                    OP_AND:   state_next = S_AND;
                    OP_NOT:   state_next = S_NOT;
                    OP_BR:    state_next = S_BR;
                    OP_JMP:   state_next = S_JMP;
                    OP_JSR:   state_next = S_JSR_SAVE;
                    OP_LDR:   state_next = S_LDR_MAR;
                    OP_STR:   state_next = S_STR_MAR;
                    OP_PAUSE: state_next = S_PAUSE_1;
                    default:  state_next = S_FETCH_MAR;
                endcase
            end
            S_BR:         state_next = ben_i ? S_BR_TAKEN : S_FETCH_MAR;
            S_JSR_SAVE:   state_next = S_JSR_JUMP;
            S_LDR_MAR:    state_next = S_LDR_RD;
            S_LDR_RD:     state_next = S_LDR_WAIT;
            S_LDR_WAIT:   state_next = S_LDR_REG;
            S_STR_MAR:    state_next = S_STR_MDR;
            S_STR_MDR:    state_next = S_STR_WR;
            S_PAUSE_1:    if (continue_i) state_next = S_PAUSE_2;
            S_PAUSE_2:    if (!continue_i) state_next = S_FETCH_MAR;
            // Last cycle of every other instruction
            default:      state_next = S_FETCH_MAR;
        endcase
    end

    // --------------------------------------------------
    // Output decode
    // --------------------------------------------------
    always_comb begin
        ld_mar_o    = 1'b0;
        ld_mdr_o    = 1'b0;
        ld_ir_o     = 1'b0;
        ld_pc_o     = 1'b0;
        ld_reg_o    = 1'b0;
        ld_cc_o     = 1'b0;
        ld_ben_o    = 1'b0;
        ld_led_o    = 1'b0;
        bus_sel_o   = BUS_PC;
        aluk_o      = ALU_PASSA;
        pcmux_o     = PC_PLUS1;
        addr2_sel_o = ADDR2_ZERO;
        addr1_sel_o = 1'b0;
        sr1_sel_o   = 1'b0;
        sr2_sel_o   = 1'b0;
        dr_sel_o    = 1'b0;
        mio_sel_o   = 1'b0;
        mem_ena_o   = 1'b0;
        mem_we_o    = 1'b0;
        paused_o    = 1'b0;
        case (state)
            // Idle counts as paused so the program port owns the RAM
            S_HALTED: paused_o = 1'b1;
            S_FETCH_MAR: begin
                ld_mar_o = 1'b1;
                ld_pc_o  = 1'b1;
            end
            S_FETCH_RD, S_LDR_RD: mem_ena_o = 1'b1;
            S_FETCH_WAIT, S_LDR_WAIT: begin
                ld_mdr_o  = 1'b1;
                mio_sel_o = 1'b1;
            end
            S_FETCH_IR: begin
                bus_sel_o = BUS_MDR;
                ld_ir_o   = 1'b1;
            end
            S_DECODE: ld_ben_o = 1'b1;
            S_ADD, S_AND, S_NOT: begin
                sr1_sel_o = 1'b1;
                sr2_sel_o = ir_i[5];
                bus_sel_o = BUS_ALU;
                ld_reg_o  = 1'b1;
                ld_cc_o   = 1'b1;
                if (state == S_ADD) begin
                    aluk_o = ALU_ADD;
                end else if (state == S_AND) begin
                    aluk_o = ALU_AND;
                end else begin
                    aluk_o = ALU_NOT;
                end
            end
            S_BR_TAKEN: begin
                addr2_sel_o = ADDR2_OFF9;
                pcmux_o     = PC_ADDER;
                ld_pc_o     = 1'b1;
            end
            // BaseR + 0 onto the bus, then into PC
            S_JMP: begin
                sr1_sel_o   = 1'b1;
                addr1_sel_o = 1'b1;
                bus_sel_o   = BUS_MARMUX;
                pcmux_o     = PC_BUS;
                ld_pc_o     = 1'b1;
            end
            S_JSR_SAVE: begin
                dr_sel_o = 1'b1;
                ld_reg_o = 1'b1;
            end
            S_JSR_JUMP: begin
                addr2_sel_o = ADDR2_OFF11;
                pcmux_o     = PC_ADDER;
                ld_pc_o     = 1'b1;
            end
            S_LDR_MAR, S_STR_MAR: begin
                sr1_sel_o   = 1'b1;
                addr1_sel_o = 1'b1;
                addr2_sel_o = ADDR2_OFF6;
                bus_sel_o   = BUS_MARMUX;
                ld_mar_o    = 1'b1;
            end
            S_LDR_REG: begin
                bus_sel_o = BUS_MDR;
                ld_reg_o  = 1'b1;
                ld_cc_o   = 1'b1;
            end
            // Source register is IR[11:9] for a store
            S_STR_MDR: begin
                bus_sel_o = BUS_ALU;
                ld_mdr_o  = 1'b1;
            end
            S_STR_WR: begin
                mem_ena_o = 1'b1;
                mem_we_o  = 1'b1;
            end
            S_PAUSE_1: begin
                ld_led_o = 1'b1;
                paused_o = 1'b1;
            end
            default: ;
        endcase
    end

endmodule

// ==== rtl/reg_file.sv ====
`timescale 1ns/1ns

module reg_file (
    input  logic                   clk,
    input  logic                   rst_i,
    input  logic                   ld_reg_i,
    input  slc3_isa_pkg::reg_idx_t dr_i,
    input  slc3_isa_pkg::reg_idx_t sr1_i,
    input  slc3_isa_pkg::reg_idx_t sr2_i,
    input  slc3_isa_pkg::word_t    bus_i,
    output slc3_isa_pkg::word_t    sr1_o,
    output slc3_isa_pkg::word_t    sr2_o
);

    import slc3_isa_pkg::*;

    word_t               regs [NUM_REGS];
    logic [NUM_REGS-1:0] wr_en;

    // One-hot write decode
    assign wr_en = ld_reg_i ? (NUM_REGS'(1) << dr_i) : '0;

    for (genvar i = 0; i < NUM_REGS; i++) begin : g_reg
        always_ff @(posedge clk) begin
            if (rst_i) begin
                regs[i] <= '0;
            end else if (wr_en[i]) begin
                regs[i] <= bus_i;
            end
        end
    end

    // Read ports
    assign sr1_o = regs[sr1_i];
    assign sr2_o = regs[sr2_i];

endmodule

// ==== rtl/slc3_ctrl_pkg.sv ====
package slc3_ctrl_pkg;

    // Control states, grouped by phase
    typedef enum logic [4:0] {
        S_HALTED,
        S_FETCH_MAR, S_FETCH_RD, S_FETCH_WAIT, S_FETCH_IR, S_DECODE,
        S_ADD, S_AND, S_NOT,
        S_BR, S_BR_TAKEN,
        S_JMP, S_JSR_SAVE, S_JSR_JUMP,
        S_LDR_MAR, S_LDR_RD, S_LDR_WAIT, S_LDR_REG,
        S_STR_MAR, S_STR_MDR, S_STR_WR,
        S_PAUSE_1, S_PAUSE_2
    } state_e;

    // --------------------------------------------------
    // Datapath select encodings
    // --------------------------------------------------
    typedef enum logic [1:0] {ALU_ADD, ALU_AND, ALU_NOT, ALU_PASSA} aluk_e;

    typedef enum logic [1:0] {PC_PLUS1, PC_BUS, PC_ADDER} pcmux_e;

    typedef enum logic [1:0] {ADDR2_ZERO, ADDR2_OFF6, ADDR2_OFF9, ADDR2_OFF11} addr2_e;

    // One driver on the bus at a time
    typedef enum logic [1:0] {BUS_PC, BUS_MDR, BUS_ALU, BUS_MARMUX} bus_sel_e;

endpackage

// ==== rtl/slc3_isa_pkg.sv ====
package slc3_isa_pkg;

    // --------------------------------------------------
    // Widths
    // --------------------------------------------------
    localparam int WORD_W     = 16;
    localparam int REG_IDX_W  = 3;
    localparam int NUM_REGS   = 8;
    localparam int MEM_ADDR_W = 8;
    localparam int MEM_DEPTH  = 256;
    localparam int LED_W      = 12;

    typedef logic [WORD_W-1:0]     word_t;
    typedef logic [REG_IDX_W-1:0]  reg_idx_t;
    typedef logic [MEM_ADDR_W-1:0] mem_addr_t;

    // --------------------------------------------------
    // Opcodes, IR[15:12]
    // --------------------------------------------------
    // PAUSE takes the slot of the LC-3 reserved opcode
    typedef enum logic [3:0] {
        OP_BR    = 4'b0000,
        OP_ADD   = 4'b0001,
        OP_JSR   = 4'b0100,
        OP_AND   = 4'b0101,
        OP_LDR   = 4'b0110,
        OP_STR   = 4'b0111,
        OP_NOT   = 4'b1001,
        OP_JMP   = 4'b1100,
        OP_PAUSE = 4'b1101
    } opcode_e;

endpackage

// ==== rtl/slc3_top.sv ====
`timescale 1ns/1ns

module slc3_top (
    input  logic                           clk,
    input  logic                           rst_i,
    input  logic                           run_i,
    input  logic                           continue_i,
    input  logic                           prog_we_i,
    input  slc3_isa_pkg::mem_addr_t        prog_addr_i,
    input  slc3_isa_pkg::word_t            prog_data_i,
    output slc3_isa_pkg::word_t            prog_rdata_o,
    output logic [slc3_isa_pkg::LED_W-1:0] led_o,
    output slc3_isa_pkg::word_t            hex_o,
    output logic                           paused_o
);

    import slc3_isa_pkg::*;

    word_t mem_rdata, mem_wdata, mem_addr;
    logic  mem_ena, mem_we;

    cpu u_cpu (
        .clk(clk), .rst_i(rst_i), .run_i(run_i), .continue_i(continue_i),
        .mem_rdata_i(mem_rdata), .mem_wdata_o(mem_wdata), .mem_addr_o(mem_addr),
        .mem_ena_o(mem_ena), .mem_we_o(mem_we),
        .led_o(led_o), .hex_o(hex_o), .paused_o(paused_o)
    );

    // Low address bits pick the word; idle processor hands the RAM to the program port
    sync_sram u_sram (
        .clk(clk),
        .cpu_addr_i(mem_addr[MEM_ADDR_W-1:0]), .cpu_wdata_i(mem_wdata),
        .cpu_ena_i(mem_ena), .cpu_we_i(mem_we),
        .prog_sel_i(paused_o), .prog_we_i(prog_we_i),
        .prog_addr_i(prog_addr_i), .prog_data_i(prog_data_i),
        .rdata_o(mem_rdata)
    );

    // Shared read register serves both ports
    assign prog_rdata_o = mem_rdata;

endmodule

// ==== rtl/sync_sram.sv ====
`timescale 1ns/1ns

module sync_sram (
    input  logic                    clk,
    input  slc3_isa_pkg::mem_addr_t cpu_addr_i,
    input  slc3_isa_pkg::word_t     cpu_wdata_i,
    input  logic                    cpu_ena_i,
    input  logic                    cpu_we_i,
    input  logic                    prog_sel_i,
    input  logic                    prog_we_i,
    input  slc3_isa_pkg::mem_addr_t prog_addr_i,
    input  slc3_isa_pkg::word_t     prog_data_i,
    output slc3_isa_pkg::word_t     rdata_o
);

    import slc3_isa_pkg::*;

    word_t     mem [MEM_DEPTH];
    mem_addr_t addr;
    word_t     wdata;
    logic      we;
    logic      re;

    // Program port in front of the processor port
    assign addr  = prog_sel_i ? prog_addr_i : cpu_addr_i;
    assign wdata = prog_sel_i ? prog_data_i : cpu_wdata_i;
    assign we    = prog_sel_i ? prog_we_i : (cpu_ena_i && cpu_we_i);
    // Program side reads every cycle
    assign re    = prog_sel_i || (cpu_ena_i && !cpu_we_i);

    always_ff @(posedge clk) begin
        if (we) mem[addr] <= wdata;
        if (re) rdata_o <= mem[addr];
    end

endmodule

// ==== slc3_top.f ====
rtl/slc3_isa_pkg.sv
rtl/slc3_ctrl_pkg.sv
rtl/reg_file.sv
rtl/cpu_control.sv
rtl/cpu.sv
rtl/sync_sram.sv
rtl/slc3_top.sv
dv/slc3_tb.sv
